//--- axi_sim_pkg.sv
// AXI simulation responder shared definitions

package axi_sim_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    // byte address
    localparam int ADDR_W = 32;

    // data word and its byte strobes
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // latency down-counter, enough for 0..15 wait cycles
    localparam int LAT_W = 4;

    ////////////////////
    // channel state
    ////////////////////

    // IDLE takes an address, WAIT counts latency,
    // DATA holds wready open (write only), RESP holds the response valid
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        WAIT = 2'd1,
        DATA = 2'd2,
        RESP = 2'd3
    } chan_state_t;

    ////////////////////
    // response codes
    ////////////////////

    // AXI two-bit response field
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

endpackage

//--- scratch_memory.sv
// Byte-strobed scratch memory
`timescale 1ns/1ps

module scratch_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                             clk,

    // read port, one cycle of latency
    input  logic                             rd_en,
    input  logic [$clog2(MEM_WORDS)-1:0]     rd_word,
    output logic [axi_sim_pkg::DATA_W-1:0]   rd_data,

    // write port
    input  logic                             wr_en,
    input  logic [$clog2(MEM_WORDS)-1:0]     wr_word,
    input  logic [axi_sim_pkg::DATA_W-1:0]   wr_data,
    input  logic [axi_sim_pkg::STRB_W-1:0]   wr_strb
);
    import axi_sim_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    ////////////////////
    // write port
    ////////////////////

    // each strobe bit enables one byte lane
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_word][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // old contents on a same-edge write, rd_data holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_word];
        end
    end

endmodule

//--- axi_read_channel.sv
// AXI read channel with fixed latency
`timescale 1ns/1ps

module axi_read_channel #(
    parameter int READ_LATENCY = 5,
    parameter int MEM_WORDS    = 256
) (
    input  logic                             clk,
    input  logic                             rst,

    // read address
    input  logic [axi_sim_pkg::ADDR_W-1:0]   araddr,
    input  logic                             arvalid,
    output logic                             arready,

    // read data
    output logic [axi_sim_pkg::DATA_W-1:0]   rdata,
    output axi_sim_pkg::axi_resp_t           rresp,
    output logic                             rvalid,
    input  logic                             rready,

    // scratch memory read port
    output logic                             mem_rd_en,
    output logic [$clog2(MEM_WORDS)-1:0]     mem_rd_word,
    input  logic [axi_sim_pkg::DATA_W-1:0]   mem_rd_data
);
    import axi_sim_pkg::*;

    localparam int WORD_W = $clog2(MEM_WORDS);

    chan_state_t      state;
    logic [LAT_W-1:0] count;
    logic             capture;
    logic             ar_fire;
    logic             r_fire;

    ////////////////////
    // handshakes
    ////////////////////

    assign arready = (state == IDLE);
    assign rvalid  = (state == RESP);
    assign ar_fire = arvalid & arready;
    assign r_fire  = rvalid & rready;

    // memory samples the word index on the acceptance edge
    assign mem_rd_en   = ar_fire;
    assign mem_rd_word = araddr[WORD_W+1:2];

    // no error path in this responder
    assign rresp = RESP_OKAY;

    ////////////////////
    // control FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            count   <= '0;
            capture <= 1'b0;
        end else begin
            // memory data is ready one edge after acceptance
            capture <= ar_fire;

            unique case (state)
                IDLE: begin
                    if (ar_fire) begin
                        count <= LAT_W'(READ_LATENCY);
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (count == '0) begin
                        state <= RESP;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                RESP: begin
                    // next address accepted only after the data beat
                    if (r_fire) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // read data
    ////////////////////

    // held until the r handshake since only one read is in flight
    always_ff @(posedge clk) begin
        if (capture) begin
            rdata <= mem_rd_data;
        end
    end

endmodule

//--- axi_write_channel.sv
// AXI write channel with fixed latency and console capture
`timescale 1ns/1ps

module axi_write_channel #(
    parameter int          WRITE_LATENCY = 5,
    parameter int          MEM_WORDS     = 256,
    parameter logic [13:0] CONSOLE_ADDR  = 14'h1000
) (
    input  logic                             clk,
    input  logic                             rst,

    // write address
    input  logic [axi_sim_pkg::ADDR_W-1:0]   awaddr,
    input  logic                             awvalid,
    output logic                             awready,

    // write data
    input  logic [axi_sim_pkg::DATA_W-1:0]   wdata,
    input  logic [axi_sim_pkg::STRB_W-1:0]   wstrb,
    input  logic                             wvalid,
    output logic                             wready,

    // write response
    output axi_sim_pkg::axi_resp_t           bresp,
    output logic                             bvalid,
    input  logic                             bready,

    // scratch memory write port
    output logic                             mem_wr_en,
    output logic [$clog2(MEM_WORDS)-1:0]     mem_wr_word,
    output logic [axi_sim_pkg::DATA_W-1:0]   mem_wr_data,
    output logic [axi_sim_pkg::STRB_W-1:0]   mem_wr_strb,

    // console output
    output logic                             console_valid,
    output logic [7:0]                       console_byte
);
    import axi_sim_pkg::*;

    localparam int WORD_W = $clog2(MEM_WORDS);

    chan_state_t       state;
    logic [LAT_W-1:0]  count;
    logic [WORD_W-1:0] word_q;
    logic              is_console;
    logic              aw_fire;
    logic              w_fire;
    logic              b_fire;

    ////////////////////
    // handshakes
    ////////////////////

    assign awready = (state == IDLE);
    assign wready  = (state == DATA);
    assign bvalid  = (state == RESP);

    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;
    assign b_fire  = bvalid & bready;

    // always OKAY, console writes included
    assign bresp = RESP_OKAY;

    ////////////////////
    // data beat steering
    ////////////////////

    // console writes never reach the memory
    assign mem_wr_en   = w_fire & ~is_console;
    assign mem_wr_word = word_q;
    assign mem_wr_data = wdata;
    assign mem_wr_strb = wstrb;

    ////////////////////
    // control FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            count         <= '0;
            console_valid <= 1'b0;
        end else begin
            // single-cycle strobe on the w handshake
            console_valid <= w_fire & is_console;

            unique case (state)
                IDLE: begin
                    if (aw_fire) begin
                        count <= LAT_W'(WRITE_LATENCY);
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (count == '0) begin
                        state <= DATA;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                DATA: begin
                    // wready stays open until the master offers data
                    if (w_fire) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (b_fire) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // address and console byte
    ////////////////////

    // decode once on the latched address, low 14 bits only
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            word_q     <= awaddr[WORD_W+1:2];
            is_console <= (awaddr[13:0] == CONSOLE_ADDR);
        end
        if (w_fire && is_console) begin
            console_byte <= wdata[7:0];
        end
    end

endmodule

//--- axi_sim_responder.sv
// AXI simulation responder top level
`timescale 1ns/1ps

module axi_sim_responder #(
    parameter int          READ_LATENCY  = 5,
    parameter int          WRITE_LATENCY = 5,
    parameter int          MEM_WORDS     = 256,
    parameter logic [13:0] CONSOLE_ADDR  = 14'h1000
) (
    input  logic                             clk,
    input  logic                             rst,

    // read address
    input  logic [axi_sim_pkg::ADDR_W-1:0]   araddr,
    input  logic                             arvalid,
    output logic                             arready,

    // read data
    output logic [axi_sim_pkg::DATA_W-1:0]   rdata,
    output axi_sim_pkg::axi_resp_t           rresp,
    output logic                             rvalid,
    input  logic                             rready,

    // write address
    input  logic [axi_sim_pkg::ADDR_W-1:0]   awaddr,
    input  logic                             awvalid,
    output logic                             awready,

    // write data
    input  logic [axi_sim_pkg::DATA_W-1:0]   wdata,
    input  logic [axi_sim_pkg::STRB_W-1:0]   wstrb,
    input  logic                             wvalid,
    output logic                             wready,

    // write response
    output axi_sim_pkg::axi_resp_t           bresp,
    output logic                             bvalid,
    input  logic                             bready,

    // console
    output logic                             console_valid,
    output logic [7:0]                       console_byte
);
    import axi_sim_pkg::*;

    localparam int WORD_W = $clog2(MEM_WORDS);

    // read channel to memory
    logic              mem_rd_en;
    logic [WORD_W-1:0] mem_rd_word;
    logic [DATA_W-1:0] mem_rd_data;

    // write channel to memory
    logic              mem_wr_en;
    logic [WORD_W-1:0] mem_wr_word;
    logic [DATA_W-1:0] mem_wr_data;
    logic [STRB_W-1:0] mem_wr_strb;

    axi_read_channel #(
        .READ_LATENCY (READ_LATENCY),
        .MEM_WORDS    (MEM_WORDS)
    ) read_i (
        .clk, .rst,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .mem_rd_en, .mem_rd_word, .mem_rd_data
    );

    axi_write_channel #(
        .WRITE_LATENCY (WRITE_LATENCY),
        .MEM_WORDS     (MEM_WORDS),
        .CONSOLE_ADDR  (CONSOLE_ADDR)
    ) write_i (
        .clk, .rst,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .mem_wr_en, .mem_wr_word, .mem_wr_data, .mem_wr_strb,
        .console_valid, .console_byte
    );

    scratch_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_i (
        .clk     (clk),
        .rd_en   (mem_rd_en),
        .rd_word (mem_rd_word),
        .rd_data (mem_rd_data),
        .wr_en   (mem_wr_en),
        .wr_word (mem_wr_word),
        .wr_data (mem_wr_data),
        .wr_strb (mem_wr_strb)
    );

endmodule

//--- axi_sim_responder_tb.sv
// AXI simulation responder testbench
`timescale 1ns/1ps

module axi_sim_responder_tb;
    import axi_sim_pkg::*;

    localparam int          READ_LATENCY  = 5;
    localparam int          WRITE_LATENCY = 5;
    localparam int          MEM_WORDS     = 256;
    localparam logic [13:0] CONSOLE_ADDR  = 14'h1000;

    localparam int WORD_W       = $clog2(MEM_WORDS);
    localparam int HIGH_W       = ADDR_W - WORD_W - 2;
    localparam int RESET_CYCLES = 16;
    localparam int ROUND_TRIPS  = 40;
    localparam int HS_LIMIT     = READ_LATENCY + WRITE_LATENCY + 20;

    // round trips are two writes and a read, plus back-pressure and console
    localparam int N_TRANS  = ROUND_TRIPS * 3 + 2 + 3;
    localparam int WD_LIMIT = N_TRANS * HS_LIMIT + RESET_CYCLES + 100;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    axi_resp_t         rresp;
    logic              rvalid;
    logic              rready;
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    axi_resp_t         bresp;
    logic              bvalid;
    logic              bready;
    logic              console_valid;
    logic [7:0]        console_byte;

    logic [31:0]       lfsr_state;
    logic [DATA_W-1:0] model [MEM_WORDS];
    int                errors;
    int                checks;

    axi_sim_responder #(
        .READ_LATENCY  (READ_LATENCY),
        .WRITE_LATENCY (WRITE_LATENCY),
        .MEM_WORDS     (MEM_WORDS),
        .CONSOLE_ADDR  (CONSOLE_ADDR)
    ) dut_i (
        .clk, .rst,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .console_valid, .console_byte
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // expected word after a strobed write
    function automatic logic [DATA_W-1:0] merge_strobes(input logic [DATA_W-1:0] old_word,
                                                         input logic [DATA_W-1:0] new_word,
                                                         input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    ////////////////////
    // bus transactions
    ////////////////////

    // starts and ends on a rising edge; hold keeps rready low after rvalid
    task automatic read_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                             input int hold);
        int n;
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= (hold == 0);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < HS_LIMIT);
        arvalid <= 1'b0;
        if (!arready) begin
            errors++;
            $display("read address was never accepted");
            return;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rvalid && n < HS_LIMIT);
        if (!rvalid) begin
            errors++;
            $display("read data never arrived");
            return;
        end
        // rise edge counted from the ar handshake
        check_value("read latency", 32'(n - 1), 32'(READ_LATENCY + 1));
        if (hold > 0) begin
            repeat (hold) begin
                @(posedge clk);
                check_value("rvalid", 32'(rvalid), 32'd1);
                check_value("rdata", rdata, exp);
                check_value("arready", 32'(arready), 32'd0);
            end
            rready <= 1'b1;
            @(posedge clk);
        end
        check_value("rvalid", 32'(rvalid), 32'd1);
        check_value("rdata", rdata, exp);
        check_value("rresp", 32'(rresp), 32'(RESP_OKAY));
        rready <= 1'b0;
    endtask

    // hold keeps bready low after bvalid
    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] strb, input int hold,
                              input logic to_console);
        int n;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        bready  <= (hold == 0);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!awready && n < HS_LIMIT);
        awvalid <= 1'b0;
        if (!awready) begin
            errors++;
            wvalid <= 1'b0;
            $display("write address was never accepted");
            return;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!wready && n < HS_LIMIT);
        wvalid <= 1'b0;
        if (!wready) begin
            errors++;
            $display("write data was never accepted");
            return;
        end
        check_value("write latency", 32'(n - 1), 32'(WRITE_LATENCY + 1));
        check_value("console_valid", 32'(console_valid), 32'd0);

        // first edge after the w handshake
        @(posedge clk);
        check_value("console_valid", 32'(console_valid), 32'(to_console));
        if (to_console) begin
            check_value("console_byte", 32'(console_byte), 32'(data[7:0]));
        end
        if (hold > 0) begin
            repeat (hold) begin
                check_value("bvalid", 32'(bvalid), 32'd1);
                check_value("awready", 32'(awready), 32'd0);
                @(posedge clk);
                check_value("console_valid", 32'(console_valid), 32'd0);
            end
            bready <= 1'b1;
            @(posedge clk);
        end
        check_value("bvalid", 32'(bvalid), 32'd1);
        check_value("bresp", 32'(bresp), 32'(RESP_OKAY));
        bready <= 1'b0;
        if (hold == 0) begin
            @(posedge clk);
            check_value("console_valid", 32'(console_valid), 32'd0);
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        logic [WORD_W-1:0] idx;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic [7:0]        cbyte;

        errors     = 0;
        checks     = 0;
        lfsr_state = 32'd86101;
        rst     <= 1'b1;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_value("arready", 32'(arready), 32'd1);
        check_value("awready", 32'(awready), 32'd1);
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_value("wready", 32'(wready), 32'd0);
        check_value("bvalid", 32'(bvalid), 32'd0);
        check_value("console_valid", 32'(console_valid), 32'd0);

        // full write, partial write, read back; index 0 aliases the console
        for (int i = 0; i < ROUND_TRIPS; i++) begin
            idx = WORD_W'(take_bits(WORD_W));
            if (idx == '0) begin
                idx = 1;
            end
            addr = {HIGH_W'(take_bits(HIGH_W)), idx, 2'b00};
            data = take_bits(DATA_W);
            write_word(addr, data, '1, 0, 1'b0);
            model[idx] = merge_strobes(model[idx], data, '1);
            data = take_bits(DATA_W);
            strb = STRB_W'(take_bits(STRB_W));
            write_word(addr, data, strb, 0, 1'b0);
            model[idx] = merge_strobes(model[idx], data, strb);
            read_word(addr, model[idx], 0);
        end

        // back-pressure on both response channels
        data = take_bits(DATA_W);
        strb = STRB_W'(take_bits(STRB_W));
        write_word(addr, data, strb, 10, 1'b0);
        model[idx] = merge_strobes(model[idx], data, strb);
        read_word(addr, model[idx], 10);

        // word 0 seeded, then a console write that must leave it alone
        data = take_bits(DATA_W);
        write_word('0, data, '1, 0, 1'b0);
        model[0] = merge_strobes(model[0], data, '1);
        cbyte = 8'(take_bits(8));
        data  = {24'(take_bits(24)), cbyte};
        write_word({18'(take_bits(18)), CONSOLE_ADDR}, data, '1, 0, 1'b1);
        read_word('0, model[0], 0);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WD_LIMIT) @(posedge clk);
        $display("simulation did not finish within %0d cycles", WD_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- axi_sim_responder.f
axi_sim_pkg.sv
scratch_memory.sv
axi_read_channel.sv
axi_write_channel.sv
axi_sim_responder.sv
axi_sim_responder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the responder testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module axi_sim_responder_tb \
    -f axi_sim_responder.f \
    -o sim_tb

./obj_dir/sim_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
